// ==== tomasulo_pkg.sv ====
package tomasulo_pkg;

  localparam int rob_tag_len = 4;
  localparam int xlen = 32;
  localparam int imm_len = 16;
  localparam int num_regs = 8;
  localparam int reg_idx_len = $clog2(num_regs);
  localparam int rs_depth = 4;
  localparam int rs_idx_len = $clog2(rs_depth);
  localparam int rs_count_len = $clog2(rs_depth + 1);
  localparam int dmem_words = 64;
  localparam int dmem_addr_len = $clog2(dmem_words);

  typedef enum logic [2:0] {
    op_add,
    op_sub,
    op_mul,
    op_addi,
    op_ld,
    op_st
  } op_t;

  typedef struct packed {
    op_t                    op;
    logic [reg_idx_len-1:0] rd;
    logic [reg_idx_len-1:0] rs1;
    logic [reg_idx_len-1:0] rs2;
    logic [imm_len-1:0]     imm;
    logic [rob_tag_len-1:0] rob_tag;
  } instr_t;

  // tag is the producer while ready is low
  typedef struct packed {
    logic [xlen-1:0]        value;
    logic [rob_tag_len-1:0] tag;
    logic                   ready;
  } operand_t;

  typedef struct packed {
    op_t                    op;
    logic [rob_tag_len-1:0] rd_tag;
    logic [imm_len-1:0]     imm;
  } alu_payload_t;

  typedef struct packed {
    logic                   is_store;
    logic [rob_tag_len-1:0] rd_tag;
    logic [imm_len-1:0]     imm;
  } mem_payload_t;

  typedef struct packed {
    logic                   valid;
    logic [rob_tag_len-1:0] rob_tag;
    logic [xlen-1:0]        value;
    logic                   write_reg;
  } cdb_t;

  typedef struct packed {
    logic                   valid;
    logic [rob_tag_len-1:0] rob_tag;
    logic [xlen-1:0]        value;
    logic                   write_reg;
  } fu_result_t;

  function automatic logic [xlen-1:0] sext_imm(logic [imm_len-1:0] imm);
    return {{(xlen - imm_len){imm[imm_len-1]}}, imm};
  endfunction

  // tag 0 never waits, so it never matches
  function automatic logic cdb_hit(cdb_t bus, logic [rob_tag_len-1:0] tag);
    return bus.valid && bus.write_reg && (bus.rob_tag == tag) && (tag != '0);
  endfunction

endpackage

// ==== dispatch_stage.sv ====
`timescale 1ns/1ps

module dispatch_stage (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        in_valid,
  input  tomasulo_pkg::instr_t        in_instr,
  output logic                        in_ready,
  input  tomasulo_pkg::cdb_t          cdb,
  input  logic                        alu_full,
  input  logic                        mem_full,
  output logic                        alu_alloc,
  output logic                        mem_alloc,
  output tomasulo_pkg::alu_payload_t  alu_payload,
  output tomasulo_pkg::mem_payload_t  mem_payload,
  output tomasulo_pkg::operand_t      src1,
  output tomasulo_pkg::operand_t      src2
);

  logic [tomasulo_pkg::rob_tag_len-1:0] reg_tag [tomasulo_pkg::num_regs];
  logic [tomasulo_pkg::xlen-1:0]        reg_value [tomasulo_pkg::num_regs];
  logic is_mem;
  logic accept;
  logic writes_rd;

  // register read with bypass from the current broadcast
  function automatic tomasulo_pkg::operand_t rename(
    logic [tomasulo_pkg::rob_tag_len-1:0] tag,
    logic [tomasulo_pkg::xlen-1:0]        value,
    tomasulo_pkg::cdb_t                   bus
  );
    tomasulo_pkg::operand_t op;
    op.value = value;
    op.tag = tag;
    op.ready = (tag == '0);
    if (tomasulo_pkg::cdb_hit(bus, tag)) begin
      op.value = bus.value;
      op.ready = 1'b1;
    end
    return op;
  endfunction

  assign is_mem = (in_instr.op == tomasulo_pkg::op_ld) || (in_instr.op == tomasulo_pkg::op_st);
  assign writes_rd = (in_instr.op != tomasulo_pkg::op_st);
  assign in_ready = is_mem ? !mem_full : !alu_full;
  assign accept = in_valid && in_ready;
  assign alu_alloc = accept && !is_mem;
  assign mem_alloc = accept && is_mem;

  assign alu_payload.op = in_instr.op;
  assign alu_payload.rd_tag = in_instr.rob_tag;
  assign alu_payload.imm = in_instr.imm;
  assign mem_payload.is_store = (in_instr.op == tomasulo_pkg::op_st);
  assign mem_payload.rd_tag = in_instr.rob_tag;
  assign mem_payload.imm = in_instr.imm;

  always_comb begin
    src1 = rename(reg_tag[in_instr.rs1], reg_value[in_instr.rs1], cdb);
    src2 = rename(reg_tag[in_instr.rs2], reg_value[in_instr.rs2], cdb);
    if (in_instr.op == tomasulo_pkg::op_addi) begin
      src2 = '{value: tomasulo_pkg::sext_imm(in_instr.imm), tag: '0, ready: 1'b1};
    end else if (in_instr.op == tomasulo_pkg::op_ld) begin
      // loads have no second source
      src2 = '{value: '0, tag: '0, ready: 1'b1};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < tomasulo_pkg::num_regs; i++) begin
        reg_tag[i] <= '0;
        reg_value[i] <= '0;
      end
    end else begin
      for (int i = 0; i < tomasulo_pkg::num_regs; i++) begin
        if (tomasulo_pkg::cdb_hit(cdb, reg_tag[i])) begin
          reg_value[i] <= cdb.value;
          reg_tag[i] <= '0;
        end
      end
      // a new rename wins over a same-cycle write-back
      if (accept && writes_rd) begin
        reg_tag[in_instr.rd] <= in_instr.rob_tag;
      end
    end
  end

endmodule

// ==== reservation_station.sv ====
`timescale 1ns/1ps

module reservation_station #(
  parameter type payload_t = tomasulo_pkg::alu_payload_t,
  parameter bit  in_order  = 1'b0
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          alloc,
  input  payload_t                      alloc_payload,
  input  tomasulo_pkg::operand_t        alloc_src1,
  input  tomasulo_pkg::operand_t        alloc_src2,
  output logic                          full,
  input  tomasulo_pkg::cdb_t            cdb,
  input  logic                          fu_busy,
  output logic                          issue_valid,
  output payload_t                      issue_payload,
  output logic [tomasulo_pkg::xlen-1:0] issue_a,
  output logic [tomasulo_pkg::xlen-1:0] issue_b
);

  typedef struct packed {
    logic                                valid;
    logic [tomasulo_pkg::rs_idx_len-1:0] age;
    payload_t                            payload;
    tomasulo_pkg::operand_t              src1;
    tomasulo_pkg::operand_t              src2;
  } entry_t;

  entry_t entries [tomasulo_pkg::rs_depth];
  logic [tomasulo_pkg::rs_count_len-1:0] count;
  logic [tomasulo_pkg::rs_depth-1:0]     ready_vec;
  logic                                  found;
  logic [tomasulo_pkg::rs_idx_len-1:0]   sel;
  logic [tomasulo_pkg::rs_idx_len-1:0]   free_idx;
  logic [tomasulo_pkg::rs_idx_len-1:0]   new_age;

  // age 0 is the oldest entry in program order
  always_comb begin
    for (int i = 0; i < tomasulo_pkg::rs_depth; i++) begin
      ready_vec[i] = entries[i].valid && entries[i].src1.ready && entries[i].src2.ready &&
                     (!in_order || entries[i].age == '0);
    end
  end

  // oldest ready entry
  always_comb begin
    found = 1'b0;
    sel = '0;
    for (int i = 0; i < tomasulo_pkg::rs_depth; i++) begin
      if (ready_vec[i] && (!found || entries[i].age < entries[sel].age)) begin
        found = 1'b1;
        sel = tomasulo_pkg::rs_idx_len'(i);
      end
    end
  end

  always_comb begin
    free_idx = '0;
    for (int i = tomasulo_pkg::rs_depth - 1; i >= 0; i--) begin
      if (!entries[i].valid) begin
        free_idx = tomasulo_pkg::rs_idx_len'(i);
      end
    end
  end

  assign full = (count == tomasulo_pkg::rs_count_len'(tomasulo_pkg::rs_depth));
  assign new_age = tomasulo_pkg::rs_idx_len'(count - tomasulo_pkg::rs_count_len'(issue_valid));

  assign issue_valid = found && !fu_busy;
  assign issue_payload = entries[sel].payload;
  assign issue_a = entries[sel].src1.value;
  assign issue_b = entries[sel].src2.value;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < tomasulo_pkg::rs_depth; i++) begin
        entries[i].valid <= 1'b0;
      end
      count <= '0;
    end else begin
      for (int i = 0; i < tomasulo_pkg::rs_depth; i++) begin
        // wakeup from the broadcast
        if (!entries[i].src1.ready && tomasulo_pkg::cdb_hit(cdb, entries[i].src1.tag)) begin
          entries[i].src1.value <= cdb.value;
          entries[i].src1.ready <= 1'b1;
        end
        if (!entries[i].src2.ready && tomasulo_pkg::cdb_hit(cdb, entries[i].src2.tag)) begin
          entries[i].src2.value <= cdb.value;
          entries[i].src2.ready <= 1'b1;
        end
        // younger entries move up one place
        if (issue_valid && entries[i].valid && entries[i].age > entries[sel].age) begin
          entries[i].age <= entries[i].age - 1'b1;
        end
      end
      if (issue_valid) begin
        entries[sel].valid <= 1'b0;
      end
      if (alloc) begin
        entries[free_idx].valid <= 1'b1;
        entries[free_idx].age <= new_age;
        entries[free_idx].payload <= alloc_payload;
        entries[free_idx].src1 <= alloc_src1;
        entries[free_idx].src2 <= alloc_src2;
      end
      count <= count + tomasulo_pkg::rs_count_len'(alloc) -
               tomasulo_pkg::rs_count_len'(issue_valid);
    end
  end

endmodule

// ==== alu_unit.sv ====
`timescale 1ns/1ps

module alu_unit (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          issue_valid,
  input  tomasulo_pkg::alu_payload_t    issue_payload,
  input  logic [tomasulo_pkg::xlen-1:0] issue_a,
  input  logic [tomasulo_pkg::xlen-1:0] issue_b,
  output logic                          busy,
  output tomasulo_pkg::fu_result_t      result,
  input  logic                          grant
);

  logic [tomasulo_pkg::xlen-1:0] alu_out;

  always_comb begin
    case (issue_payload.op)
      tomasulo_pkg::op_sub:  alu_out = issue_a - issue_b;
      // low word of the product
      tomasulo_pkg::op_mul:  alu_out = issue_a * issue_b;
      tomasulo_pkg::op_addi: alu_out = issue_a + tomasulo_pkg::sext_imm(issue_payload.imm);
      default:               alu_out = issue_a + issue_b;
    endcase
  end

  // a result waiting for the bus blocks the next issue
  assign busy = result.valid && !grant;

  always_ff @(posedge clk) begin
    if (reset) begin
      result.valid <= 1'b0;
    end else if (issue_valid) begin
      result.valid <= 1'b1;
      result.rob_tag <= issue_payload.rd_tag;
      result.value <= alu_out;
      result.write_reg <= 1'b1;
    end else if (grant) begin
      result.valid <= 1'b0;
    end
  end

endmodule

// ==== mem_unit.sv ====
`timescale 1ns/1ps

module mem_unit (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          issue_valid,
  input  tomasulo_pkg::mem_payload_t    issue_payload,
  input  logic [tomasulo_pkg::xlen-1:0] issue_a,
  input  logic [tomasulo_pkg::xlen-1:0] issue_b,
  output logic                          busy,
  output tomasulo_pkg::fu_result_t      result,
  input  logic                          grant
);

  logic [tomasulo_pkg::xlen-1:0]          dmem [tomasulo_pkg::dmem_words];
  logic [tomasulo_pkg::xlen-1:0]          ea;
  logic [tomasulo_pkg::dmem_addr_len-1:0] addr;

  // word address wraps around the store
  assign ea = issue_a + tomasulo_pkg::sext_imm(issue_payload.imm);
  assign addr = ea[tomasulo_pkg::dmem_addr_len-1:0];

  assign busy = result.valid && !grant;

  // stores land at issue so a following load sees them
  always_ff @(posedge clk) begin
    if (issue_valid && issue_payload.is_store) begin
      dmem[addr] <= issue_b;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      result.valid <= 1'b0;
    end else if (issue_valid) begin
      result.valid <= 1'b1;
      result.rob_tag <= issue_payload.rd_tag;
      result.write_reg <= !issue_payload.is_store;
      if (issue_payload.is_store) begin
        result.value <= issue_b;
      end else begin
        result.value <= dmem[addr];
      end
    end else if (grant) begin
      result.valid <= 1'b0;
    end
  end

endmodule

// ==== cdb_arbiter.sv ====
`timescale 1ns/1ps

module cdb_arbiter (
  input  logic                     clk,
  input  logic                     reset,
  input  tomasulo_pkg::fu_result_t alu_result,
  input  tomasulo_pkg::fu_result_t mem_result,
  output logic                     alu_grant,
  output logic                     mem_grant,
  output tomasulo_pkg::cdb_t       cdb
);

  tomasulo_pkg::fu_result_t winner;

  // alu first, memory waits
  assign alu_grant = alu_result.valid;
  assign mem_grant = mem_result.valid && !alu_result.valid;
  assign winner = alu_result.valid ? alu_result : mem_result;

  always_ff @(posedge clk) begin
    if (reset) begin
      cdb.valid <= 1'b0;
    end else begin
      cdb.valid <= alu_grant || mem_grant;
      cdb.rob_tag <= winner.rob_tag;
      cdb.value <= winner.value;
      cdb.write_reg <= winner.write_reg;
    end
  end

endmodule

// ==== issue_core.sv ====
`timescale 1ns/1ps

module issue_core (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 in_valid,
  input  tomasulo_pkg::instr_t in_instr,
  output logic                 in_ready,
  output tomasulo_pkg::cdb_t   cdb
);

  logic                          alu_alloc;
  logic                          mem_alloc;
  logic                          alu_full;
  logic                          mem_full;
  tomasulo_pkg::alu_payload_t    alu_payload;
  tomasulo_pkg::mem_payload_t    mem_payload;
  tomasulo_pkg::operand_t        src1;
  tomasulo_pkg::operand_t        src2;

  logic                          alu_issue_valid;
  tomasulo_pkg::alu_payload_t    alu_issue_payload;
  logic [tomasulo_pkg::xlen-1:0] alu_issue_a;
  logic [tomasulo_pkg::xlen-1:0] alu_issue_b;
  logic                          mem_issue_valid;
  tomasulo_pkg::mem_payload_t    mem_issue_payload;
  logic [tomasulo_pkg::xlen-1:0] mem_issue_a;
  logic [tomasulo_pkg::xlen-1:0] mem_issue_b;

  logic                          alu_busy;
  logic                          mem_busy;
  tomasulo_pkg::fu_result_t      alu_result;
  tomasulo_pkg::fu_result_t      mem_result;
  logic                          alu_grant;
  logic                          mem_grant;

  dispatch_stage dispatch (
    .clk(clk), .reset(reset),
    .in_valid(in_valid), .in_instr(in_instr), .in_ready(in_ready),
    .cdb(cdb), .alu_full(alu_full), .mem_full(mem_full),
    .alu_alloc(alu_alloc), .mem_alloc(mem_alloc),
    .alu_payload(alu_payload), .mem_payload(mem_payload),
    .src1(src1), .src2(src2)
  );

  reservation_station #(
    .payload_t(tomasulo_pkg::alu_payload_t),
    .in_order(1'b0)
  ) alu_rs (
    .clk(clk), .reset(reset),
    .alloc(alu_alloc), .alloc_payload(alu_payload),
    .alloc_src1(src1), .alloc_src2(src2), .full(alu_full),
    .cdb(cdb), .fu_busy(alu_busy),
    .issue_valid(alu_issue_valid), .issue_payload(alu_issue_payload),
    .issue_a(alu_issue_a), .issue_b(alu_issue_b)
  );

  // memory ops leave in program order
  reservation_station #(
    .payload_t(tomasulo_pkg::mem_payload_t),
    .in_order(1'b1)
  ) mem_rs (
    .clk(clk), .reset(reset),
    .alloc(mem_alloc), .alloc_payload(mem_payload),
    .alloc_src1(src1), .alloc_src2(src2), .full(mem_full),
    .cdb(cdb), .fu_busy(mem_busy),
    .issue_valid(mem_issue_valid), .issue_payload(mem_issue_payload),
    .issue_a(mem_issue_a), .issue_b(mem_issue_b)
  );

  alu_unit alu_fu (
    .clk(clk), .reset(reset),
    .issue_valid(alu_issue_valid), .issue_payload(alu_issue_payload),
    .issue_a(alu_issue_a), .issue_b(alu_issue_b),
    .busy(alu_busy), .result(alu_result), .grant(alu_grant)
  );

  mem_unit mem_fu (
    .clk(clk), .reset(reset),
    .issue_valid(mem_issue_valid), .issue_payload(mem_issue_payload),
    .issue_a(mem_issue_a), .issue_b(mem_issue_b),
    .busy(mem_busy), .result(mem_result), .grant(mem_grant)
  );

  cdb_arbiter cdb_arb (
    .clk(clk), .reset(reset),
    .alu_result(alu_result), .mem_result(mem_result),
    .alu_grant(alu_grant), .mem_grant(mem_grant),
    .cdb(cdb)
  );

endmodule

// ==== issue_core_sva.sv ====
`timescale 1ns/1ps

module issue_core_sva (
  input logic                     clk,
  input logic                     reset,
  input logic                     mem_grant,
  input tomasulo_pkg::fu_result_t mem_result,
  input logic                     alu_full,
  input logic                     mem_full,
  input logic                     alu_issue_valid,
  input logic                     mem_issue_valid,
  input tomasulo_pkg::cdb_t       cdb
);

  // the memory result that loses the bus waits unchanged for its grant
  mem_holds: assert property (@(posedge clk) disable iff (reset)
    mem_result.valid && !mem_grant |=> mem_result.valid && $stable(mem_result))
    else $error("memory result changed while it waited for the bus");

  quiet_in_reset: assert property (@(posedge clk) reset |=> !cdb.valid)
    else $error("cdb valid after a reset cycle");

  // a full station takes nothing until it issues
  alu_stays_full: assert property (@(posedge clk) disable iff (reset)
    alu_full && !alu_issue_valid |=> alu_full)
    else $error("ALU station took an entry while full");

  mem_stays_full: assert property (@(posedge clk) disable iff (reset)
    mem_full && !mem_issue_valid |=> mem_full)
    else $error("memory station took an entry while full");

endmodule

bind issue_core issue_core_sva issue_core_sva_i (
  .clk(clk), .reset(reset),
  .mem_grant(mem_grant), .mem_result(mem_result),
  .alu_full(alu_full), .mem_full(mem_full),
  .alu_issue_valid(alu_issue_valid), .mem_issue_valid(mem_issue_valid),
  .cdb(cdb)
);

// ==== issue_core_tb.sv ====
`timescale 1ns/1ps

module issue_core_tb;

  typedef logic [tomasulo_pkg::xlen-1:0]          word_t;
  typedef logic [tomasulo_pkg::rob_tag_len-1:0]   tag_t;
  typedef logic [tomasulo_pkg::dmem_addr_len-1:0] addr_t;
  typedef logic [tomasulo_pkg::reg_idx_len-1:0]   reg_t;
  typedef logic [tomasulo_pkg::imm_len-1:0]       imm_t;

  localparam int num_tags = 2 ** tomasulo_pkg::rob_tag_len;
  localparam int ext_len = tomasulo_pkg::xlen - tomasulo_pkg::imm_len;
  localparam int num_random = 200;
  // 24 directed, the random ones, one readback per register
  localparam int num_instr = 24 + num_random + tomasulo_pkg::num_regs;
  localparam int max_cycles = 40 * num_instr + 200;
  localparam int drain_cycles = 40 * num_tags;

  logic                 clk;
  logic                 reset;
  logic                 in_valid;
  tomasulo_pkg::instr_t in_instr;
  logic                 in_ready;
  tomasulo_pkg::cdb_t   cdb;

  word_t              model_reg [tomasulo_pkg::num_regs];
  word_t              model_mem [tomasulo_pkg::dmem_words];
  bit                 written [tomasulo_pkg::dmem_words];
  tomasulo_pkg::cdb_t expected [num_tags];
  bit                 pending [num_tags];
  bit                 is_mem_tag [num_tags];
  int                 done_order [num_tags];
  tag_t               mem_order [$];
  tag_t               next_tag;
  int                 done_count;
  int                 mismatch_count;
  int                 fail_count;
  bit                 saw_stall;

  issue_core issue_core_i (
    .clk(clk), .reset(reset),
    .in_valid(in_valid), .in_instr(in_instr), .in_ready(in_ready),
    .cdb(cdb)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // in-order execution of one instruction on the model state
  function automatic tomasulo_pkg::cdb_t ref_exec(tomasulo_pkg::instr_t ins);
    tomasulo_pkg::cdb_t res;
    word_t a;
    word_t b;
    word_t imm;
    word_t ea;
    a = model_reg[ins.rs1];
    b = model_reg[ins.rs2];
    imm = {{ext_len{ins.imm[tomasulo_pkg::imm_len-1]}}, ins.imm};
    ea = a + imm;
    res = '0;
    res.valid = 1'b1;
    res.rob_tag = ins.rob_tag;
    res.write_reg = 1'b1;
    case (ins.op)
      tomasulo_pkg::op_add:  res.value = a + b;
      tomasulo_pkg::op_sub:  res.value = a - b;
      tomasulo_pkg::op_mul:  res.value = a * b;
      tomasulo_pkg::op_addi: res.value = a + imm;
      tomasulo_pkg::op_ld:   res.value = model_mem[addr_t'(ea)];
      default: begin
        // store reports its data
        model_mem[addr_t'(ea)] = b;
        written[addr_t'(ea)] = 1'b1;
        res.value = b;
        res.write_reg = 1'b0;
      end
    endcase
    if (res.write_reg) begin
      model_reg[ins.rd] = res.value;
    end
    return res;
  endfunction

  task automatic check_cdb(tomasulo_pkg::cdb_t exp, tomasulo_pkg::cdb_t got);
    if (got.value !== exp.value) begin
      mismatch_count++;
      $display("mismatch cdb.value for tag %h: got %h, expected %h",
               got.rob_tag, got.value, exp.value);
    end
    if (got.write_reg !== exp.write_reg) begin
      mismatch_count++;
      $display("mismatch cdb.write_reg for tag %h: got %h, expected %h",
               got.rob_tag, got.write_reg, exp.write_reg);
    end
  endtask

  task automatic check_reg_count();
    foreach (pending[i]) begin
      if (pending[i]) begin
        fail_count++;
        $display("tag %0d was dispatched but never appeared on the CDB", i);
      end
    end
  endtask

  // called on a falling edge, returns on a falling edge
  task automatic send(tomasulo_pkg::op_t op, int rd, int rs1, int rs2, imm_t imm,
                      output tag_t tag);
    tomasulo_pkg::instr_t ins;
    tag = next_tag;
    next_tag = (next_tag == '1) ? tag_t'(1) : tag_t'(next_tag + 1'b1);
    while (pending[tag]) begin
      @(negedge clk);
    end
    ins.op = op;
    ins.rd = reg_t'(rd);
    ins.rs1 = reg_t'(rs1);
    ins.rs2 = reg_t'(rs2);
    ins.imm = imm;
    ins.rob_tag = tag;
    in_valid = 1'b1;
    in_instr = ins;
    // in_ready settles once the new instruction is on the input
    #1;
    while (!in_ready) begin
      saw_stall = 1'b1;
      @(negedge clk);
      #1;
    end
    @(posedge clk);
    expected[tag] = ref_exec(ins);
    is_mem_tag[tag] = (op == tomasulo_pkg::op_ld) || (op == tomasulo_pkg::op_st);
    if (is_mem_tag[tag]) begin
      mem_order.push_back(tag);
    end
    pending[tag] = 1'b1;
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic drain();
    bit busy;
    int waited;
    busy = 1'b1;
    waited = 0;
    while (busy && waited < drain_cycles) begin
      busy = 1'b0;
      foreach (pending[i]) begin
        busy |= pending[i];
      end
      if (busy) begin
        @(negedge clk);
        waited++;
      end
    end
  endtask

  task automatic send_random();
    tomasulo_pkg::op_t op;
    int                rs1;
    int                start;
    addr_t             target;
    addr_t             offset;
    imm_t              imm;
    tag_t              tag;
    op = tomasulo_pkg::op_t'($urandom_range(0, 5));
    rs1 = $urandom_range(0, tomasulo_pkg::num_regs - 1);
    imm = imm_t'($urandom());
    if (op == tomasulo_pkg::op_ld) begin
      // aim the load at a word that holds data, else store instead
      start = $urandom_range(0, tomasulo_pkg::dmem_words - 1);
      op = tomasulo_pkg::op_st;
      for (int i = 0; i < tomasulo_pkg::dmem_words; i++) begin
        target = addr_t'(start + i);
        if (op != tomasulo_pkg::op_ld && written[target]) begin
          op = tomasulo_pkg::op_ld;
          offset = target - addr_t'(model_reg[rs1]);
          imm = imm_t'(offset);
        end
      end
    end
    send(op, $urandom_range(0, tomasulo_pkg::num_regs - 1), rs1,
         $urandom_range(0, tomasulo_pkg::num_regs - 1), imm, tag);
  endtask

  initial begin : compare
    tag_t mem_tag;
    @(negedge reset);
    forever begin
      @(negedge clk);
      if (cdb.valid === 1'b1) begin
        if (!pending[cdb.rob_tag]) begin
          fail_count++;
          $display("tag %0d was broadcast with no instruction waiting for it", cdb.rob_tag);
        end else begin
          check_cdb(expected[cdb.rob_tag], cdb);
          if (is_mem_tag[cdb.rob_tag]) begin
            mem_tag = mem_order.pop_front();
            if (mem_tag != cdb.rob_tag) begin
              fail_count++;
              $display("memory op tag %0d completed ahead of older tag %0d",
                       cdb.rob_tag, mem_tag);
            end
          end
          pending[cdb.rob_tag] = 1'b0;
          done_order[cdb.rob_tag] = done_count;
          done_count++;
        end
      end else if (cdb.valid !== 1'b0) begin
        fail_count++;
        $display("cdb.valid is unknown after reset");
      end
    end
  end

  initial begin : watchdog
    repeat (max_cycles) @(posedge clk);
    $display("run did not finish within %0d cycles", max_cycles);
    $display("errors: %0d mismatches, %0d other", mismatch_count, fail_count);
    $display("Result: FAILED");
    $finish;
  end

  initial begin : main
    tag_t t;
    tag_t t_last_ld;
    tag_t t_add;
    void'($urandom(32'h5228776e));
    reset = 1'b1;
    in_valid = 1'b0;
    in_instr = '0;
    next_tag = tag_t'(1);
    done_count = 0;
    mismatch_count = 0;
    fail_count = 0;
    for (int i = 0; i < tomasulo_pkg::num_regs; i++) begin
      model_reg[i] = '0;
    end
    repeat (8) @(negedge clk);
    reset = 1'b0;

    // load feeding a multiply
    send(tomasulo_pkg::op_addi, 1, 0, 0, 16'd12, t);
    send(tomasulo_pkg::op_st, 0, 0, 1, 16'd3, t);
    send(tomasulo_pkg::op_ld, 2, 0, 0, 16'd3, t);
    send(tomasulo_pkg::op_addi, 3, 0, 0, 16'd5, t);
    send(tomasulo_pkg::op_mul, 4, 2, 3, 16'd0, t);
    drain();

    // independent add against a chain of dependent loads
    send(tomasulo_pkg::op_addi, 4, 0, 0, 16'd7, t);
    send(tomasulo_pkg::op_st, 0, 0, 4, 16'd5, t);
    send(tomasulo_pkg::op_st, 0, 0, 4, 16'd7, t);
    send(tomasulo_pkg::op_ld, 1, 0, 0, 16'd5, t);
    send(tomasulo_pkg::op_ld, 2, 1, 0, 16'd0, t);
    send(tomasulo_pkg::op_ld, 5, 2, 0, 16'd0, t_last_ld);
    send(tomasulo_pkg::op_add, 3, 4, 4, 16'd0, t_add);
    drain();
    if (done_order[t_add] > done_order[t_last_ld]) begin
      fail_count++;
      $display("add tag %0d did not overtake the waiting load tag %0d", t_add, t_last_ld);
    end

    // more waiting adds than the ALU station holds
    saw_stall = 1'b0;
    send(tomasulo_pkg::op_ld, 6, 0, 0, 16'd5, t);
    for (int i = 0; i < 3; i++) begin
      send(tomasulo_pkg::op_ld, 6, 6, 0, 16'd0, t);
    end
    for (int i = 0; i < 8; i++) begin
      send(tomasulo_pkg::op_add, 1 + i % 5, 6, 6, 16'd0, t);
    end
    drain();
    if (!saw_stall) begin
      fail_count++;
      $display("in_ready never dropped while the ALU station was full");
    end

    for (int i = 0; i < num_random; i++) begin
      send_random();
    end
    // read every register back through the bus
    for (int r = 0; r < tomasulo_pkg::num_regs; r++) begin
      send(tomasulo_pkg::op_addi, r, r, 0, 16'd0, t);
    end
    drain();
    check_reg_count();

    $display("errors: %0d mismatches, %0d other", mismatch_count, fail_count);
    if (mismatch_count == 0 && fail_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
tomasulo_pkg.sv
dispatch_stage.sv
reservation_station.sv
alu_unit.sv
mem_unit.sv
cdb_arbiter.sv
issue_core.sv
issue_core_sva.sv
issue_core_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module issue_core_tb \
  -f flist.f -o issue_core_sim
status=0
./obj_dir/issue_core_sim > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q "Result: FAILED" sim.log; then
  exit 1
fi
grep -q "Result: PASSED" sim.log
